// ==== src/issue_pkg.sv ====
// Issue stage package

package issue_pkg;

    // ------------------------------------------------------------
    // widths and counts
    // ------------------------------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned REG_ADDR_W      = 5;
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned TRANS_ID_W      = 3;

    // ------------------------------------------------------------
    // functional units
    // ------------------------------------------------------------
    // NONE also marks a free entry in the clobber table
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        LOAD      = 3'd3,
        STORE     = 3'd4,
        MULT      = 3'd5,
        CSR       = 3'd6
    } fu_e;

    // ------------------------------------------------------------
    // operators carried to execute
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        BEQ   = 4'd7,
        BNE   = 4'd8,
        LW    = 4'd9,
        SW    = 4'd10,
        MUL   = 4'd11,
        CSRRW = 4'd12
    } fu_op_e;

endpackage

// ==== src/int_regfile.sv ====
// Integer register file

module int_regfile import issue_pkg::*; (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    // read ports
    input  logic [REG_ADDR_W-1:0]                       raddr_a_i,
    input  logic [REG_ADDR_W-1:0]                       raddr_b_i,
    output logic [XLEN-1:0]                             rdata_a_o,
    output logic [XLEN-1:0]                             rdata_b_o,
    // commit write ports
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]  waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]        wdata_i,
    input  logic [NR_COMMIT_PORTS-1:0]                  we_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NR_REGS-1];

    // ------------------------------------------------------------
    // write with later ports overriding earlier ones
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // combinational read
    // ------------------------------------------------------------
    // writes in the same cycle are not visible here
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== src/operand_hazard.sv ====
// Issue hazard and acknowledge logic

module operand_hazard import issue_pkg::*; (
    input  logic                                        instr_valid_i,
    input  fu_e                                         fu_i,
    input  logic [REG_ADDR_W-1:0]                       rs1_i,
    input  logic [REG_ADDR_W-1:0]                       rs2_i,
    input  logic [REG_ADDR_W-1:0]                       rd_i,
    input  logic                                        use_zimm_i,
    input  logic                                        ex_valid_i,
    // scoreboard state
    input  fu_e  [NR_REGS-1:0]                          rd_clobber_i,
    input  logic                                        fwd_rs1_valid_i,
    input  logic                                        fwd_rs2_valid_i,
    // unit readiness
    input  logic                                        alu_ready_i,
    input  logic                                        branch_ready_i,
    input  logic                                        lsu_ready_i,
    // commit ports
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]  waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0]                  we_i,
    // multiply dispatched last cycle
    input  logic                                        mult_pending_i,
    output logic                                        forward_rs1_o,
    output logic                                        forward_rs2_o,
    output logic                                        issue_ack_o,
    output logic                                        dispatch_o
);

    logic fu_busy;
    logic rs1_pending;
    logic rs2_pending;
    logic stall;
    logic rd_free;

    // ------------------------------------------------------------
    // unit busy
    // ------------------------------------------------------------
    // mult shares the alu port, csr shares the branch port
    always_comb begin : unit_busy
        case (fu_i)
            ALU, MULT:      fu_busy = !alu_ready_i;
            CTRL_FLOW, CSR: fu_busy = !branch_ready_i;
            LOAD, STORE:    fu_busy = !lsu_ready_i;
            default:        fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // source operands
    // ------------------------------------------------------------
    // zimm replaces rs1, so there is nothing to wait for
    assign rs1_pending = !use_zimm_i && (rd_clobber_i[rs1_i] != NONE);
    assign rs2_pending = rd_clobber_i[rs2_i] != NONE;

    // csr results only arrive through the register file
    assign forward_rs1_o = rs1_pending && fwd_rs1_valid_i && (rd_clobber_i[rs1_i] != CSR);
    assign forward_rs2_o = rs2_pending && fwd_rs2_valid_i && (rd_clobber_i[rs2_i] != CSR);

    assign stall = (rs1_pending && !forward_rs1_o) || (rs2_pending && !forward_rs2_o);

    // ------------------------------------------------------------
    // write after write
    // ------------------------------------------------------------
    always_comb begin : rd_check
        rd_free = rd_clobber_i[rd_i] == NONE;
        // a commit writing rd this cycle releases it
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == rd_i)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (instr_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions pass through
            if ((ex_valid_i && !fu_busy) || (fu_i == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // keep the fixed latency result bus free of contention
        if (mult_pending_i && (fu_i != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign dispatch_o = issue_ack_o && !ex_valid_i;

endmodule

// ==== src/operand_select.sv ====
// Operand selection

module operand_select import issue_pkg::*; (
    input  logic [XLEN-1:0]       rf_rs1_i,
    input  logic [XLEN-1:0]       rf_rs2_i,
    input  logic [XLEN-1:0]       fwd_rs1_data_i,
    input  logic [XLEN-1:0]       fwd_rs2_data_i,
    input  logic                  forward_rs1_i,
    input  logic                  forward_rs2_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  use_imm_i,
    input  logic                  use_pc_i,
    input  logic                  use_zimm_i,
    input  fu_e                   fu_i,
    output logic [XLEN-1:0]       operand_a_o,
    output logic [XLEN-1:0]       operand_b_o,
    output logic [XLEN-1:0]       imm_o
);

    always_comb begin : select_a
        operand_a_o = forward_rs1_i ? fwd_rs1_data_i : rf_rs1_i;
        if (use_pc_i) begin
            operand_a_o = pc_i;
        end
        // zimm is the raw rs1 field, zero extended
        if (use_zimm_i) begin
            operand_a_o = {{(XLEN-REG_ADDR_W){1'b0}}, rs1_i};
        end
    end

    always_comb begin : select_b
        operand_b_o = forward_rs2_i ? fwd_rs2_data_i : rf_rs2_i;
        // stores and branches keep rs2 and pass the immediate separately
        if (use_imm_i && (fu_i != STORE) && (fu_i != CTRL_FLOW)) begin
            operand_b_o = imm_i;
        end
    end

    assign imm_o = imm_i;

endmodule

// ==== src/dispatch_regs.sv ====
// ID to EX pipeline register

module dispatch_regs import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  dispatch_i,
    input  fu_e                   fu_i,
    input  fu_op_e                op_i,
    input  logic [XLEN-1:0]       operand_a_i,
    input  logic [XLEN-1:0]       operand_b_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [TRANS_ID_W-1:0] trans_id_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  is_compressed_i,
    // unit strobes
    output logic                  alu_valid_o,
    output logic                  branch_valid_o,
    output logic                  lsu_valid_o,
    output logic                  mult_valid_o,
    output logic                  csr_valid_o,
    // payload toward execute
    output fu_e                   fu_o,
    output fu_op_e                operator_o,
    output logic [XLEN-1:0]       operand_a_o,
    output logic [XLEN-1:0]       operand_b_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [TRANS_ID_W-1:0] trans_id_o,
    output logic [XLEN-1:0]       pc_o,
    output logic                  is_compressed_o
);

    logic [4:0] valid_n;
    logic [4:0] valid_q;
    logic       is_branch;

    // ------------------------------------------------------------
    // unit strobes
    // ------------------------------------------------------------
    // bit order: alu, branch, lsu, mult, csr
    always_comb begin : strobe_decode
        valid_n = '0;
        if (dispatch_i) begin
            case (fu_i)
                ALU:         valid_n[0] = 1'b1;
                CTRL_FLOW:   valid_n[1] = 1'b1;
                LOAD, STORE: valid_n[2] = 1'b1;
                MULT:        valid_n[3] = 1'b1;
                CSR:         valid_n[4] = 1'b1;
                default:     valid_n = '0;
            endcase
        end
    end

    // flush drops the strobes so no unit starts on stale operands
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_n;
        end
    end

    assign {csr_valid_o, mult_valid_o, lsu_valid_o, branch_valid_o, alu_valid_o} = valid_q;

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    // pc only matters to the branch unit
    assign is_branch = dispatch_i && (fu_i == CTRL_FLOW);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_o            <= NONE;
            operator_o      <= ADD;
            operand_a_o     <= '0;
            operand_b_o     <= '0;
            imm_o           <= '0;
            trans_id_o      <= '0;
            pc_o            <= '0;
            is_compressed_o <= 1'b0;
        end else begin
            fu_o            <= fu_i;
            operator_o      <= op_i;
            operand_a_o     <= operand_a_i;
            operand_b_o     <= operand_b_i;
            imm_o           <= imm_i;
            trans_id_o      <= trans_id_i;
            pc_o            <= is_branch ? pc_i : '0;
            is_compressed_o <= is_branch && is_compressed_i;
        end
    end

endmodule

// ==== src/issue_read_operands.sv ====
// Issue and operand read stage

module issue_read_operands import issue_pkg::*; (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        flush_i,
    // instruction from the scoreboard
    input  logic                                        instr_valid_i,
    input  fu_e                                         fu_i,
    input  fu_op_e                                      op_i,
    input  logic [REG_ADDR_W-1:0]                       rs1_i,
    input  logic [REG_ADDR_W-1:0]                       rs2_i,
    input  logic [REG_ADDR_W-1:0]                       rd_i,
    input  logic [XLEN-1:0]                             imm_i,
    input  logic [XLEN-1:0]                             pc_i,
    input  logic [TRANS_ID_W-1:0]                       trans_id_i,
    input  logic                                        use_imm_i,
    input  logic                                        use_pc_i,
    input  logic                                        use_zimm_i,
    input  logic                                        is_compressed_i,
    input  logic                                        ex_valid_i,
    output logic                                        issue_ack_o,
    // scoreboard lookup
    input  fu_e  [NR_REGS-1:0]                          rd_clobber_i,
    output logic [REG_ADDR_W-1:0]                       rs1_o,
    output logic [REG_ADDR_W-1:0]                       rs2_o,
    input  logic [XLEN-1:0]                             fwd_rs1_data_i,
    input  logic                                        fwd_rs1_valid_i,
    input  logic [XLEN-1:0]                             fwd_rs2_data_i,
    input  logic                                        fwd_rs2_valid_i,
    // execute units
    input  logic                                        alu_ready_i,
    input  logic                                        branch_ready_i,
    input  logic                                        lsu_ready_i,
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        csr_valid_o,
    output fu_e                                         fu_o,
    output fu_op_e                                      operator_o,
    output logic [XLEN-1:0]                             operand_a_o,
    output logic [XLEN-1:0]                             operand_b_o,
    output logic [XLEN-1:0]                             imm_o,
    output logic [TRANS_ID_W-1:0]                       trans_id_o,
    output logic [XLEN-1:0]                             pc_o,
    output logic                                        is_compressed_o,
    // commit ports
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]  waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]        wdata_i,
    input  logic [NR_COMMIT_PORTS-1:0]                  we_i
);

    logic [XLEN-1:0] rf_rs1, rf_rs2;
    logic            forward_rs1, forward_rs2;
    logic            dispatch;
    logic [XLEN-1:0] operand_a_n, operand_b_n, imm_n;

    assign rs1_o = rs1_i;
    assign rs2_o = rs2_i;

    int_regfile i_int_regfile (
        .clk_i, .rst_ni, .raddr_a_i(rs1_i), .raddr_b_i(rs2_i),
        .rdata_a_o(rf_rs1), .rdata_b_o(rf_rs2), .waddr_i, .wdata_i, .we_i
    );

    operand_hazard i_operand_hazard (
        .instr_valid_i, .fu_i, .rs1_i, .rs2_i, .rd_i, .use_zimm_i, .ex_valid_i,
        .rd_clobber_i, .fwd_rs1_valid_i, .fwd_rs2_valid_i, .alu_ready_i,
        .branch_ready_i, .lsu_ready_i, .waddr_i, .we_i, .mult_pending_i(mult_valid_o),
        .forward_rs1_o(forward_rs1), .forward_rs2_o(forward_rs2), .issue_ack_o,
        .dispatch_o(dispatch)
    );

    operand_select i_operand_select (
        .rf_rs1_i(rf_rs1), .rf_rs2_i(rf_rs2), .fwd_rs1_data_i, .fwd_rs2_data_i,
        .forward_rs1_i(forward_rs1), .forward_rs2_i(forward_rs2), .rs1_i, .imm_i, .pc_i,
        .use_imm_i, .use_pc_i, .use_zimm_i, .fu_i,
        .operand_a_o(operand_a_n), .operand_b_o(operand_b_n), .imm_o(imm_n)
    );

    dispatch_regs i_dispatch_regs (
        .clk_i, .rst_ni, .flush_i, .dispatch_i(dispatch), .fu_i, .op_i,
        .operand_a_i(operand_a_n), .operand_b_i(operand_b_n), .imm_i(imm_n), .trans_id_i,
        .pc_i, .is_compressed_i, .alu_valid_o, .branch_valid_o, .lsu_valid_o, .mult_valid_o,
        .csr_valid_o, .fu_o, .operator_o, .operand_a_o, .operand_b_o, .imm_o, .trans_id_o,
        .pc_o, .is_compressed_o
    );

endmodule

// ==== testbench/issue_read_operands_assert.sv ====
// Dispatch strobe assertions

module issue_read_operands_assert import issue_pkg::*; (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic alu_valid_o,
    input logic branch_valid_o,
    input logic lsu_valid_o,
    input logic mult_valid_o,
    input logic csr_valid_o
);

    logic [4:0] strobes;

    assign strobes = {csr_valid_o, mult_valid_o, lsu_valid_o, branch_valid_o, alu_valid_o};

    // one unit per issued instruction
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(strobes))
        else $error("more than one unit strobe high");

    assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> (strobes == '0))
        else $error("unit strobe high in the cycle after flush");

    assert property (@(posedge clk_i) !rst_ni |-> (strobes == '0))
        else $error("unit strobe high during reset");

endmodule

bind dispatch_regs issue_read_operands_assert i_issue_read_operands_assert (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .alu_valid_o(alu_valid_o),
    .branch_valid_o(branch_valid_o), .lsu_valid_o(lsu_valid_o),
    .mult_valid_o(mult_valid_o), .csr_valid_o(csr_valid_o)
);

// ==== testbench/tb_issue_read_operands.sv ====
// Issue stage testbench

module tb_issue_read_operands import issue_pkg::*; ();

    localparam int unsigned NUM_VEC    = 400;
    localparam int unsigned WATCHDOG_T = (20 * NUM_VEC + 100) * 10;

    logic clk_i, rst_ni, flush_i, instr_valid_i, ex_valid_i, is_compressed_i;
    logic use_imm_i, use_pc_i, use_zimm_i, fwd_rs1_valid_i, fwd_rs2_valid_i;
    logic alu_ready_i, branch_ready_i, lsu_ready_i;
    fu_e                                        fu_i;
    fu_op_e                                     op_i;
    logic [REG_ADDR_W-1:0]                      rs1_i, rs2_i, rd_i, rs1_o, rs2_o;
    logic [XLEN-1:0]                            imm_i, pc_i, fwd_rs1_data_i, fwd_rs2_data_i;
    logic [TRANS_ID_W-1:0]                      trans_id_i, trans_id_o;
    fu_e  [NR_REGS-1:0]                         rd_clobber_i;
    logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0] waddr_i;
    logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]       wdata_i;
    logic [NR_COMMIT_PORTS-1:0]                 we_i;
    logic issue_ack_o, alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o;
    fu_e                                        fu_o;
    fu_op_e                                     operator_o;
    logic [XLEN-1:0]                            operand_a_o, operand_b_o, imm_o, pc_o;
    logic                                       is_compressed_o;

    // reference model state
    logic [31:0]           seed;
    logic [XLEN-1:0]       shadow [NR_REGS];
    int unsigned           n_checks;
    int unsigned           n_errors;
    logic                  ack_seen;
    logic                  checking = 1'b0;
    // expected payload registered like the DUT
    fu_e                   e_fu;
    fu_op_e                e_op;
    logic [XLEN-1:0]       e_a, e_b, e_imm, e_pc;
    logic [TRANS_ID_W-1:0] e_tid;
    logic                  e_cmp;
    logic [4:0]            e_strb;

    issue_read_operands i_issue_read_operands (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("watchdog: simulation did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [15:0] rnd16();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic exp_issue(input logic mult_pend, output logic [XLEN-1:0] a,
                                       output logic [XLEN-1:0] b, output logic [4:0] strb);
        logic ready, fwd1, fwd2, wait1, wait2, rd_ok, ack;
        case (fu_i)
            ALU, MULT:      ready = alu_ready_i;
            CTRL_FLOW, CSR: ready = branch_ready_i;
            LOAD, STORE:    ready = lsu_ready_i;
            default:        ready = 1'b1;
        endcase
        fwd1  = rd_clobber_i[rs1_i] != NONE && fwd_rs1_valid_i && rd_clobber_i[rs1_i] != CSR;
        fwd2  = rd_clobber_i[rs2_i] != NONE && fwd_rs2_valid_i && rd_clobber_i[rs2_i] != CSR;
        wait1 = !use_zimm_i && rd_clobber_i[rs1_i] != NONE && !fwd1;
        wait2 = rd_clobber_i[rs2_i] != NONE && !fwd2;
        rd_ok = rd_clobber_i[rd_i] == NONE || (we_i[0] && waddr_i[0] == rd_i)
                || (we_i[1] && waddr_i[1] == rd_i);
        ack = instr_valid_i && ((ready && !wait1 && !wait2 && rd_ok)
                                || (ex_valid_i && ready) || fu_i == NONE);
        if (mult_pend && fu_i != MULT) ack = 1'b0;
        a = fwd1 ? fwd_rs1_data_i : shadow[rs1_i];
        if (use_pc_i) a = pc_i;
        if (use_zimm_i) a = XLEN'(rs1_i);
        b = fwd2 ? fwd_rs2_data_i : shadow[rs2_i];
        if (use_imm_i && !(fu_i inside {STORE, CTRL_FLOW})) b = imm_i;
        strb = '0;
        if (ack && !ex_valid_i) begin
            strb = {fu_i == CSR, fu_i == MULT, fu_i inside {LOAD, STORE},
                    fu_i == CTRL_FLOW, fu_i == ALU};
        end
        return ack;
    endfunction

    task automatic check_ack(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_fu(input string name, input fu_e exp, input fu_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_op(input string name, input fu_op_e exp, input fu_op_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    // a held instruction keeps its fields while the scoreboard state moves on
    task automatic drive_vector();
        logic [REG_ADDR_W-1:0] rd_n;
        logic [REG_ADDR_W-1:0] wa0;
        rd_n = rd_i;
        if (!instr_valid_i || ack_seen) begin
            rd_n = REG_ADDR_W'(rnd16());
            instr_valid_i   <= (rnd16() % 8) != 0;
            fu_i            <= fu_e'(3'(rnd16() % 7));
            op_i            <= fu_op_e'(4'(rnd16() % 13));
            rs1_i           <= REG_ADDR_W'(rnd16());
            rs2_i           <= REG_ADDR_W'(rnd16());
            imm_i           <= {rnd16(), rnd16()};
            pc_i            <= {rnd16(), rnd16()};
            trans_id_i      <= TRANS_ID_W'(rnd16());
            use_imm_i       <= (rnd16() % 3) == 0;
            use_pc_i        <= (rnd16() % 4) == 0;
            use_zimm_i      <= (rnd16() % 4) == 0;
            is_compressed_i <= (rnd16() % 2) == 0;
            ex_valid_i      <= (rnd16() % 16) == 0;
        end
        rd_i <= rd_n;
        for (int r = 1; r < NR_REGS; r++) begin
            rd_clobber_i[r] <= ((rnd16() % 4) == 0) ? fu_e'(3'(1 + rnd16() % 6)) : NONE;
        end
        fwd_rs1_data_i  <= {rnd16(), rnd16()};
        fwd_rs2_data_i  <= {rnd16(), rnd16()};
        fwd_rs1_valid_i <= (rnd16() % 4) != 0;
        fwd_rs2_valid_i <= (rnd16() % 4) != 0;
        alu_ready_i     <= (rnd16() % 8) != 0;
        branch_ready_i  <= (rnd16() % 8) != 0;
        lsu_ready_i     <= (rnd16() % 8) != 0;
        // bias commits toward rd and toward both ports hitting one register
        wa0 = ((rnd16() % 4) == 0) ? rd_n : REG_ADDR_W'(rnd16());
        waddr_i[0]      <= wa0;
        waddr_i[1]      <= ((rnd16() % 4) == 0) ? wa0 : REG_ADDR_W'(rnd16());
        wdata_i[0]      <= {rnd16(), rnd16()};
        wdata_i[1]      <= {rnd16(), rnd16()};
        we_i            <= NR_COMMIT_PORTS'(rnd16());
        flush_i         <= (rnd16() % 16) == 0;
    endtask

    initial begin : stimulus
        seed = 32'h4a2c_fb33;
        n_checks = 0;
        n_errors = 0;
        ack_seen = 1'b0;
        {e_a, e_b, e_imm, e_pc, e_tid, e_cmp, e_strb} = '0;
        e_fu = NONE;
        e_op = ADD;
        for (int r = 0; r < NR_REGS; r++) begin
            shadow[r] = '0;
            rd_clobber_i[r] = NONE;
        end
        rst_ni = 1'b1;
        {flush_i, instr_valid_i, ex_valid_i, is_compressed_i, use_imm_i, use_pc_i} = '0;
        {use_zimm_i, fwd_rs1_valid_i, fwd_rs2_valid_i} = '0;
        {alu_ready_i, branch_ready_i, lsu_ready_i} = '1;
        fu_i = NONE;
        op_i = ADD;
        {rs1_i, rs2_i, rd_i, imm_i, pc_i, trans_id_i, fwd_rs1_data_i, fwd_rs2_data_i} = '0;
        {waddr_i, wdata_i, we_i} = '0;
        #2 rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        checking = 1'b1;
        for (int n = 0; n < NUM_VEC; n++) begin
            drive_vector();
            @(posedge clk_i);
        end
        instr_valid_i <= 1'b0;
        we_i          <= '0;
        flush_i       <= 1'b0;
        @(posedge clk_i);
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // compare at mid cycle when inputs and registers are settled
    // ------------------------------------------------------------
    always @(negedge clk_i) begin : compare
        logic [XLEN-1:0] a_n;
        logic [XLEN-1:0] b_n;
        logic [4:0]      s_n;
        logic            ack_n;
        logic            br;
        if (checking) begin
            check_ack("alu_valid_o", e_strb[0], alu_valid_o);
            check_ack("branch_valid_o", e_strb[1], branch_valid_o);
            check_ack("lsu_valid_o", e_strb[2], lsu_valid_o);
            check_ack("mult_valid_o", e_strb[3], mult_valid_o);
            check_ack("csr_valid_o", e_strb[4], csr_valid_o);
            check_fu("fu_o", e_fu, fu_o);
            check_op("operator_o", e_op, operator_o);
            check_data("operand_a_o", e_a, operand_a_o);
            check_data("operand_b_o", e_b, operand_b_o);
            check_data("imm_o", e_imm, imm_o);
            check_data("trans_id_o", XLEN'(e_tid), XLEN'(trans_id_o));
            check_data("pc_o", e_pc, pc_o);
            check_ack("is_compressed_o", e_cmp, is_compressed_o);
            // scoreboard lookup addresses follow the source fields
            check_data("rs1_o", XLEN'(rs1_i), XLEN'(rs1_o));
            check_data("rs2_o", XLEN'(rs2_i), XLEN'(rs2_o));
            ack_n = exp_issue(e_strb[3], a_n, b_n, s_n);
            check_ack("issue_ack_o", ack_n, issue_ack_o);
            ack_seen = issue_ack_o;
            br = ack_n && !ex_valid_i && fu_i == CTRL_FLOW;
            e_strb = flush_i ? 5'b0 : s_n;
            e_fu = fu_i;
            e_op = op_i;
            e_a = a_n;
            e_b = b_n;
            e_imm = imm_i;
            e_tid = trans_id_i;
            e_pc = br ? pc_i : '0;
            e_cmp = br && is_compressed_i;
            // commits land on the next edge and port 1 goes last so it wins
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (we_i[p] && waddr_i[p] != '0) shadow[waddr_i[p]] = wdata_i[p];
            end
        end
    end

endmodule

// ==== issue_read_operands.f ====
src/issue_pkg.sv
src/int_regfile.sv
src/operand_hazard.sv
src/operand_select.sv
src/dispatch_regs.sv
src/issue_read_operands.sv
testbench/issue_read_operands_assert.sv
testbench/tb_issue_read_operands.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_issue_read_operands \
    -f issue_read_operands.f -o sim_issue_read_operands

./obj_dir/sim_issue_read_operands | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
